// File: verilog/jh_consts.svh
`ifndef JH_CONSTS_SVH
`define JH_CONSTS_SVH

// histogram geometry
`define JH_NUM_BINS   200
`define JH_LEVELS     10
`define JH_CI_SCALE   100
`define JH_NI_SCALE   10

// data widths
`define JH_BIN_W      8
`define JH_COUNT_W    16
`define JH_LEVEL_W    4
`define JH_DAT_W      32

// counts stick here
`define JH_COUNT_MAX  65535

// wishbone word addressing, bins below the base
`define JH_ADR_W      9
`define JH_REG_BASE   9'h100

`endif

// File: verilog/jh_pkg.sv
`include "jh_consts.svh"

package jh_pkg;

  typedef logic [`JH_BIN_W-1:0]   bin_t;
  typedef logic [`JH_COUNT_W-1:0] count_t;
  typedef logic [`JH_LEVEL_W-1:0] level_t;

  // clear sweep runs first after reset
  typedef enum logic {
    ST_CLEAR,
    ST_RUN
  } engine_state_e;

  // register offsets from the register base
  typedef enum logic [1:0] {
    REG_CTRL    = 2'd0,
    REG_STATUS  = 2'd1,
    REG_SAMPLES = 2'd2,
    REG_DROPS   = 2'd3
  } jh_reg_e;

endpackage

// File: verilog/jh_rmw_if.sv
`timescale 1ns/1ps

interface jh_rmw_if import jh_pkg::*; ();

  // read side, data returns one cycle after rd_en
  logic   rd_en;
  bin_t   rd_addr;
  count_t rd_data;

  // write side
  logic   wr_en;
  bin_t   wr_addr;
  count_t wr_data;

  modport engine (
    output rd_en, rd_addr, wr_en, wr_addr, wr_data,
    input  rd_data
  );

  modport mem (
    input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
    output rd_data
  );

endinterface

// File: verilog/jh_bin_index.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module jh_bin_index import jh_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   sample_valid_i,
  input  logic   ci_i,
  input  level_t ni_i,
  input  level_t rd_i,
  input  logic   clear_i,
  output logic   bin_valid_o,
  output bin_t   bin_o,
  output count_t drop_count_o
);

  logic in_range;
  bin_t ci_term;
  bin_t ni_term;
  bin_t ci_term_q;
  bin_t ni_term_q;
  bin_t rd_term_q;

  assign in_range = (ni_i < `JH_LEVELS) && (rd_i < `JH_LEVELS);

  // ci is one bit, so its weight is all or nothing
  assign ci_term = ci_i ? bin_t'(`JH_CI_SCALE) : '0;
  // ni * 10 as ni * 8 + ni * 2
  assign ni_term = (bin_t'(ni_i) << 3) + (bin_t'(ni_i) << 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin_valid_o <= 1'b0;
    end else begin
      bin_valid_o <= sample_valid_i & in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      ci_term_q <= ci_term;
      ni_term_q <= ni_term;
      rd_term_q <= bin_t'(rd_i);
    end
  end

  assign bin_o = ci_term_q + ni_term_q + rd_term_q;

  // out-of-range samples, counted even with counting off
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count_o <= '0;
    end else if (clear_i) begin
      drop_count_o <= '0;
    end else if (sample_valid_i && !in_range && drop_count_o != `JH_COUNT_MAX) begin
      drop_count_o <= drop_count_o + 1'b1;
    end
  end

endmodule

// File: verilog/jh_count_engine.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module jh_count_engine import jh_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     bin_valid_i,
  input  bin_t     bin_i,
  input  logic     count_en_i,
  input  logic     clear_start_i,
  jh_rmw_if.engine mem,
  output logic     clearing_o,
  output count_t   sample_count_o
);

  engine_state_e state_q;
  bin_t          clr_idx_q;
  logic          accept;
  logic          wr_valid_q;
  bin_t          wr_bin_q;
  logic          fwd_q;
  count_t        fwd_data_q;
  count_t        base;
  count_t        incr;

  assign clearing_o = (state_q == ST_CLEAR);
  assign accept     = bin_valid_i & count_en_i & ~clearing_o;

  // zero sweep over every bin, then count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ST_CLEAR;
      clr_idx_q <= '0;
    end else if (clear_start_i) begin
      state_q   <= ST_CLEAR;
      clr_idx_q <= '0;
    end else if (state_q == ST_CLEAR) begin
      if (clr_idx_q == bin_t'(`JH_NUM_BINS - 1)) begin
        state_q   <= ST_RUN;
        clr_idx_q <= '0;
      end else begin
        clr_idx_q <= clr_idx_q + 1'b1;
      end
    end
  end

  // stage 2 is the write stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid_q <= 1'b0;
      fwd_q      <= 1'b0;
    end else begin
      wr_valid_q <= accept;
      // memory returns stale data when a read meets the write of the same bin
      fwd_q      <= accept & wr_valid_q & (bin_i == wr_bin_q);
    end
  end

  always_ff @(posedge clk) begin
    wr_bin_q   <= bin_i;
    fwd_data_q <= incr;
  end

  assign base = fwd_q ? fwd_data_q : mem.rd_data;
  assign incr = (base == `JH_COUNT_MAX) ? base : base + 1'b1;

  assign mem.rd_en   = accept;
  assign mem.rd_addr = bin_i;
  // sweep owns the write port while clearing
  assign mem.wr_en   = clearing_o | wr_valid_q;
  assign mem.wr_addr = clearing_o ? clr_idx_q : wr_bin_q;
  assign mem.wr_data = clearing_o ? '0 : incr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_count_o <= '0;
    end else if (clearing_o) begin
      sample_count_o <= '0;
    end else if (accept && sample_count_o != `JH_COUNT_MAX) begin
      sample_count_o <= sample_count_o + 1'b1;
    end
  end

endmodule

// File: verilog/jh_bin_mem.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module jh_bin_mem #(
  parameter int DEPTH = `JH_NUM_BINS,
  parameter int WIDTH = `JH_COUNT_W
) (
  input  logic                     clk,
  jh_rmw_if.mem                    a,
  input  logic                     b_en_i,
  input  logic [$clog2(DEPTH)-1:0] b_addr_i,
  output logic [WIDTH-1:0]         b_data_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  // single write port, owned by the engine
  always_ff @(posedge clk) begin
    if (a.wr_en) begin
      mem_q[a.wr_addr] <= a.wr_data;
    end
  end

  // engine read, old data on a same-address write
  always_ff @(posedge clk) begin
    if (a.rd_en) begin
      a.rd_data <= mem_q[a.rd_addr];
    end
  end

  // host read port, holds its last value
  always_ff @(posedge clk) begin
    if (b_en_i) begin
      b_data_o <= mem_q[b_addr_i];
    end
  end

endmodule

// File: verilog/jh_wb_slave.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module jh_wb_slave import jh_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`JH_ADR_W-1:0] wb_adr_i,
  input  logic [`JH_DAT_W-1:0] wb_dat_i,
  output logic [`JH_DAT_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 clearing_i,
  input  count_t               sample_count_i,
  input  count_t               drop_count_i,
  output logic                 b_en_o,
  output bin_t                 b_addr_o,
  input  count_t               b_data_i,
  output logic                 clear_start_o,
  output logic                 count_en_o
);

  logic                 start;
  logic                 ctrl_wr;
  logic                 stg1_q;
  logic                 stg2_q;
  logic [`JH_ADR_W-1:0] adr_q;
  logic [`JH_ADR_W-1:0] reg_off;
  logic                 bin_hit;
  logic                 reg_hit;
  jh_reg_e              reg_sel;
  logic [`JH_DAT_W-1:0] reg_rdata;

  // new request only once the previous one has fully retired
  assign start   = wb_cyc_i & wb_stb_i & ~stg1_q & ~stg2_q & ~wb_ack_o;
  assign ctrl_wr = start & wb_we_i & (wb_adr_i == `JH_REG_BASE + 9'(REG_CTRL));

  // ack sequencer, same latency for bins and registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg1_q   <= 1'b0;
      stg2_q   <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      stg1_q   <= start;
      stg2_q   <= stg1_q;
      wb_ack_o <= stg2_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= wb_adr_i;
    end
  end

  // control register, clear bit is self-clearing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_en_o    <= 1'b0;
      clear_start_o <= 1'b0;
    end else begin
      clear_start_o <= ctrl_wr & wb_dat_i[0];
      if (ctrl_wr) begin
        count_en_o <= wb_dat_i[1];
      end
    end
  end

  assign reg_off = adr_q - `JH_REG_BASE;
  assign reg_hit = (adr_q >= `JH_REG_BASE) && (reg_off < 4);
  assign reg_sel = jh_reg_e'(reg_off[1:0]);
  // bins 200 to 255 fall through and read zero
  assign bin_hit = (adr_q < `JH_NUM_BINS);

  // bin writes are dropped, only reads touch the memory
  assign b_en_o   = stg1_q & bin_hit;
  assign b_addr_o = adr_q[`JH_BIN_W-1:0];

  always_comb begin
    reg_rdata = '0;
    if (reg_hit) begin
      case (reg_sel)
        REG_CTRL:    reg_rdata = {30'd0, count_en_o, 1'b0};
        REG_STATUS:  reg_rdata = {30'd0, count_en_o, clearing_i};
        REG_SAMPLES: reg_rdata = 32'(sample_count_i);
        REG_DROPS:   reg_rdata = 32'(drop_count_i);
        default:     reg_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stg2_q) begin
      wb_dat_o <= bin_hit ? 32'(b_data_i) : reg_rdata;
    end
  end

endmodule

// File: verilog/joint_histogram_top.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module joint_histogram_top import jh_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sample_valid_i,
  input  logic                 ci_i,
  input  level_t               ni_i,
  input  level_t               rd_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`JH_ADR_W-1:0] wb_adr_i,
  input  logic [`JH_DAT_W-1:0] wb_dat_i,
  output logic [`JH_DAT_W-1:0] wb_dat_o,
  output logic                 wb_ack_o
);

  logic   bin_valid;
  bin_t   bin;
  logic   clearing;
  logic   count_en;
  logic   clear_start;
  count_t sample_count;
  count_t drop_count;
  logic   b_en;
  bin_t   b_addr;
  count_t b_data;

  jh_rmw_if rmw ();

  jh_bin_index u_bin_index (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .ci_i           (ci_i),
    .ni_i           (ni_i),
    .rd_i           (rd_i),
    .clear_i        (clearing),
    .bin_valid_o    (bin_valid),
    .bin_o          (bin),
    .drop_count_o   (drop_count)
  );

  jh_count_engine u_count_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .bin_valid_i    (bin_valid),
    .bin_i          (bin),
    .count_en_i     (count_en),
    .clear_start_i  (clear_start),
    .mem            (rmw.engine),
    .clearing_o     (clearing),
    .sample_count_o (sample_count)
  );

  jh_bin_mem #(
    .DEPTH (`JH_NUM_BINS),
    .WIDTH (`JH_COUNT_W)
  ) u_bin_mem (
    .clk      (clk),
    .a        (rmw.mem),
    .b_en_i   (b_en),
    .b_addr_i (b_addr),
    .b_data_o (b_data)
  );

  jh_wb_slave u_wb_slave (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .clearing_i     (clearing),
    .sample_count_i (sample_count),
    .drop_count_i   (drop_count),
    .b_en_o         (b_en),
    .b_addr_o       (b_addr),
    .b_data_i       (b_data),
    .clear_start_o  (clear_start),
    .count_en_o     (count_en)
  );

endmodule

// File: dv/jh_tb.sv
`timescale 1ns/1ps
`include "jh_consts.svh"

module jh_tb import jh_pkg::*; ();

  localparam int CLK_PERIOD    = 10;
  localparam int RST_CYCLES    = 2;
  localparam int SWEEP_CYCLES  = `JH_NUM_BINS + 64;
  localparam int SCAN_CYCLES   = 256 * 8;
  localparam int NUM_SCANS     = 5;
  localparam int NUM_RANDOM    = 400;
  localparam int NUM_DROPS     = 40;
  localparam int NUM_DISABLED  = 30;
  // clear write plus status read take 9 cycles before the first sample,
  // which puts the last of these samples in the final cycle of the sweep
  localparam int NUM_IN_CLEAR  = `JH_NUM_BINS - 9;
  localparam int SAMPLE_CYCLES = NUM_RANDOM + NUM_DROPS + NUM_DISABLED + NUM_IN_CLEAR + 32;
  localparam int REG_CYCLES    = 32 * 8;
  localparam int TEST_CYCLES   = RST_CYCLES + 2 * SWEEP_CYCLES + NUM_SCANS * SCAN_CYCLES
                                 + SAMPLE_CYCLES + REG_CYCLES;

  logic                 clk;
  logic                 rst_n;
  logic                 sample_valid_i;
  logic                 ci_i;
  level_t               ni_i;
  level_t               rd_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [`JH_ADR_W-1:0] wb_adr_i;
  logic [`JH_DAT_W-1:0] wb_dat_i;
  logic [`JH_DAT_W-1:0] wb_dat_o;
  logic                 wb_ack_o;

  // model of the histogram and its statistics
  count_t ref_counts [`JH_NUM_BINS];
  count_t ref_samples;
  count_t ref_drops;

  joint_histogram_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .ci_i           (ci_i),
    .ni_i           (ni_i),
    .rd_i           (rd_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run("compare failed");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run("compare failed");
    end
  endtask

  // bin rule, -1 for a sample that is dropped
  function automatic int ref_bin(input logic ci, input level_t ni, input level_t rd);
    if (int'(ni) >= `JH_LEVELS || int'(rd) >= `JH_LEVELS) begin
      return -1;
    end
    return int'(ci) * `JH_CI_SCALE + int'(ni) * `JH_NI_SCALE + int'(rd);
  endfunction

  function automatic count_t sat_inc(input count_t v);
    return (v == count_t'(`JH_COUNT_MAX)) ? v : v + 1'b1;
  endfunction

  task automatic clear_model();
    int i;
    for (i = 0; i < `JH_NUM_BINS; i++) begin
      ref_counts[i] = '0;
    end
    ref_samples = '0;
    ref_drops   = '0;
  endtask

  // ack is due on the fourth falling edge after the request is driven
  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack_o && waited < 16);
    if (!wb_ack_o) begin
      abort_run("no Wishbone ack within 16 cycles");
    end
    if (waited != 4) begin
      abort_run($sformatf("Wishbone ack came after %0d cycles instead of 4", waited));
    end
  endtask

  task automatic wb_write(input logic [`JH_ADR_W-1:0] adr, input logic [`JH_DAT_W-1:0] dat);
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wait_ack();
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_read(input logic [`JH_ADR_W-1:0] adr, output logic [`JH_DAT_W-1:0] dat);
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    wait_ack();
    dat = wb_dat_o;
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic read_reg(input jh_reg_e r, output logic [`JH_DAT_W-1:0] dat);
    wb_read(`JH_REG_BASE + 9'(r), dat);
  endtask

  task automatic check_status(input logic exp_clearing, input logic exp_count_en);
    logic [`JH_DAT_W-1:0] dat;
    read_reg(REG_STATUS, dat);
    check_flag("STATUS.clearing", exp_clearing, dat[0]);
    check_flag("STATUS.count_en", exp_count_en, dat[1]);
  endtask

  task automatic check_counters();
    logic [`JH_DAT_W-1:0] dat;
    read_reg(REG_SAMPLES, dat);
    check_count("REG_SAMPLES", ref_samples, dat[15:0]);
    read_reg(REG_DROPS, dat);
    check_count("REG_DROPS", ref_drops, dat[15:0]);
  endtask

  // unmapped bins 200 to 255 must read zero
  task automatic check_all_bins();
    int i;
    logic [`JH_DAT_W-1:0] dat;
    count_t exp;
    for (i = 0; i < 256; i++) begin
      wb_read(9'(i), dat);
      if (i < `JH_NUM_BINS) begin
        exp = ref_counts[i];
      end else begin
        exp = '0;
      end
      check_count($sformatf("bin %0d", i), exp, dat[15:0]);
      check_count($sformatf("bin %0d upper half", i), '0, dat[31:16]);
    end
  endtask

  task automatic wait_clear_done();
    int polls;
    logic [`JH_DAT_W-1:0] dat;
    polls = 0;
    dat   = '1;
    while (dat[0] && polls < 64) begin
      read_reg(REG_STATUS, dat);
      polls++;
    end
    if (dat[0]) begin
      abort_run("clear sweep did not finish within 64 status reads");
    end
  endtask

  task automatic send_sample(input logic ci, input level_t ni, input level_t rd,
                             input logic counted);
    int idx;
    idx = ref_bin(ci, ni, rd);
    @(posedge clk);
    sample_valid_i <= 1'b1;
    ci_i           <= ci;
    ni_i           <= ni;
    rd_i           <= rd;
    if (idx < 0) begin
      ref_drops = sat_inc(ref_drops);
    end else if (counted) begin
      ref_counts[idx] = sat_inc(ref_counts[idx]);
      ref_samples     = sat_inc(ref_samples);
    end
  endtask

  // let the last update reach memory
  task automatic end_samples();
    @(posedge clk);
    sample_valid_i <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  // runs of one to four equal samples hit the forwarding path
  task automatic send_random_runs(input int total, input logic counted);
    int     sent;
    int     run;
    logic   ci;
    level_t ni;
    level_t rd;
    sent = 0;
    while (sent < total) begin
      ci  = 1'($urandom % 2);
      ni  = level_t'($urandom % `JH_LEVELS);
      rd  = level_t'($urandom % `JH_LEVELS);
      run = 1 + int'($urandom % 4);
      repeat (run) begin
        if (sent < total) begin
          send_sample(ci, ni, rd, counted);
          sent++;
        end
      end
    end
    end_samples();
  endtask

  task automatic send_out_of_range(input int total);
    int     i;
    level_t ni;
    level_t rd;
    for (i = 0; i < total; i++) begin
      if (i % 2 == 0) begin
        ni = level_t'(`JH_LEVELS + $urandom % 6);
        rd = level_t'($urandom % 16);
      end else begin
        ni = level_t'($urandom % `JH_LEVELS);
        rd = level_t'(`JH_LEVELS + $urandom % 6);
      end
      send_sample(1'($urandom % 2), ni, rd, 1'b1);
    end
    end_samples();
  endtask

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    abort_run($sformatf("run timed out after %0d cycles", 2 * TEST_CYCLES));
  end

  initial begin
    void'($urandom(32'he9a7_9087));
    rst_n          = 1'b0;
    sample_valid_i = 1'b0;
    ci_i           = 1'b0;
    ni_i           = '0;
    rd_i           = '0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    clear_model();
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // sweep starts at reset release
    check_status(1'b1, 1'b0);
    wait_clear_done();
    check_status(1'b0, 1'b0);
    check_all_bins();
    check_counters();

    // counting on, random in-range traffic
    wb_write(`JH_REG_BASE + 9'(REG_CTRL), 32'h2);
    check_status(1'b0, 1'b1);
    send_random_runs(NUM_RANDOM, 1'b1);
    check_all_bins();
    check_counters();

    send_out_of_range(NUM_DROPS);
    check_all_bins();
    check_counters();

    // bin writes are ignored, then traffic with counting off
    wb_write(9'd7, 32'h0000_1234);
    wb_write(9'd250, 32'h0000_5678);
    wb_write(`JH_REG_BASE + 9'(REG_CTRL), 32'h0);
    check_status(1'b0, 1'b0);
    send_random_runs(NUM_DISABLED, 1'b0);
    check_all_bins();
    check_counters();

    // clear with counting on, traffic during the sweep is lost
    wb_write(`JH_REG_BASE + 9'(REG_CTRL), 32'h3);
    clear_model();
    check_status(1'b1, 1'b1);
    send_random_runs(NUM_IN_CLEAR, 1'b0);
    wait_clear_done();
    check_all_bins();
    check_counters();

    $display("Everything OK");
    $finish;
  end

endmodule

// File: joint_histogram.f
+incdir+verilog
verilog/jh_pkg.sv
verilog/jh_rmw_if.sv
verilog/jh_bin_index.sv
verilog/jh_count_engine.sv
verilog/jh_bin_mem.sv
verilog/jh_wb_slave.sv
verilog/joint_histogram_top.sv
dv/jh_tb.sv

// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = jh_tb
FILELIST = joint_histogram.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
